//--- upd7800_pkg.sv
// Definitions shared by the uPD7800 peripheral block.
// Only the SPR selects of the kept registers are listed.
// Timer and serial interrupt slots remain in the index list so that
// the MK bit positions keep their usual meaning.

package upd7800_pkg;

  //////////////////////////////////////////////////////////////////////
  // Special-register selects

  typedef enum logic [3:0] {
    spr_pa = 4'd0,
    spr_pb = 4'd1,
    spr_pc = 4'd2,
    spr_mk = 4'd3,
    spr_mb = 4'd4,
    spr_mc = 4'd5
  } e_spr;

  //////////////////////////////////////////////////////////////////////
  // Interrupt sources

  // Listed in priority order, which also gives the MK bit position
  typedef enum logic [2:0] {
    ii_int0 = 3'd0,
    ii_intt = 3'd1,
    ii_int1 = 3'd2,
    ii_int2 = 3'd3,
    ii_ints = 3'd4
  } e_int_idx;

  // Pending vector holds INT0, INT1 and INT2 only
  localparam int num_int = 3;

  // Vector addresses
  localparam logic [7:0] vec_int0 = 8'h04;
  localparam logic [7:0] vec_int1 = 8'h10;
  localparam logic [7:0] vec_int2 = 8'h20;
  localparam logic [7:0] vec_none = 8'h60;

  //////////////////////////////////////////////////////////////////////
  // Reset values and sampler constants

  // All sources masked and all port bits input
  localparam logic [7:0] mk_reset   = 8'hff;
  localparam logic [7:0] mode_reset = 8'hff;

  // Sample clock is cp1 divided by 12
  localparam logic [3:0] div12_last = 4'd11;

  // One low sample then three high with the oldest in bit 3
  localparam logic [3:0] edge_pattern = 4'b0111;

endpackage

//--- spr_bus_if.sv
// Special-register access bus.
// Writes are taken on cp2_negedge cycles; rdata is combinational from sel.

`timescale 1ns/1ps

interface spr_bus_if;
  import upd7800_pkg::*;

  e_spr       sel;
  logic [7:0] wdata;
  logic       we;
  logic [7:0] rdata;

  // Driver side
  modport host (
    output sel,
    output wdata,
    output we,
    input  rdata
  );

  // Register block side
  modport regs (
    input  sel,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

//--- int_sampler.sv
// INT1/INT2 edge filter sampled by a divide-by-12 strobe off cp1.
// An edge is seen after one low sample followed by three high samples,
// so pulses shorter than three sample periods are dropped.
// INT2 is inverted when mk5 is clear, which selects falling edges.

`timescale 1ns/1ps

module int_sampler (
  input  logic CLK,
  input  logic rst,
  input  logic cp1_posedge,
  input  logic int1,
  input  logic int2,
  input  logic mk5,
  output logic set1,
  output logic set2
);
  import upd7800_pkg::*;

  logic [3:0] cnt_div12;
  logic       tick;
  logic [3:0] hist1;
  logic [3:0] hist2;
  logic       int2_pol;
  logic [3:0] next1;
  logic [3:0] next2;

  // Divide by 12
  always_ff @(posedge CLK) begin
    if (rst) begin
      cnt_div12 <= '0;
    end else if (cp1_posedge) begin
      cnt_div12 <= (cnt_div12 == div12_last) ? 4'd0 : cnt_div12 + 4'd1;
    end
  end

  assign tick = cp1_posedge & (cnt_div12 == div12_last);

  assign int2_pol = int2 ^ ~mk5;
  assign next1    = {hist1[2:0], int1};
  assign next2    = {hist2[2:0], int2_pol};

  // Sample history with the newest sample in bit 0
  always_ff @(posedge CLK) begin
    if (rst) begin
      hist1 <= '0;
      hist2 <= '0;
    end else if (tick) begin
      hist1 <= next1;
      hist2 <= next2;
    end
  end

  // One-cycle pulse on the sample that completes the pattern
  assign set1 = tick & (next1 == edge_pattern);
  assign set2 = tick & (next2 == edge_pattern);

endmodule

//--- int_controller.sv
// Interrupt controller for INT0 (level) and INT1/INT2 (filtered edge).
// Pending bits are latched with mask and IE at each fetch strobe and the
// vector follows the latched copy until the next fetch.
// Ack clears only the pending bit of the granted source.
// Priority is fixed: INT0, then INT1, then INT2.

`timescale 1ns/1ps

module int_controller (
  input  logic       CLK,
  input  logic       rst,
  input  logic       cp1_posedge,
  input  logic       cp2_negedge,
  input  logic       int0,
  input  logic       int1,
  input  logic       int2,
  input  logic       fetch,
  input  logic       ack,
  input  logic       ie,
  input  logic [7:0] mk,
  output logic       int_req,
  output logic [7:0] int_vector
);
  import upd7800_pkg::*;

  logic                set1;
  logic                set2;
  logic [num_int-1:0]  pend;
  logic [num_int-1:0]  pend_set;
  logic [num_int-1:0]  pend_clr;
  logic [num_int-1:0]  enable;
  logic [num_int-1:0]  latched;
  logic [num_int-1:0]  grant;

  int_sampler u_sampler (
    .CLK         (CLK),
    .rst         (rst),
    .cp1_posedge (cp1_posedge),
    .int1        (int1),
    .int2        (int2),
    .mk5         (mk[5]),
    .set1        (set1),
    .set2        (set2)
  );

  //////////////////////////////////////////////////////////////////////
  // Pending state

  // Bit 0 is INT0, bit 1 INT1, bit 2 INT2
  assign pend_set = {set2, set1, int0 & ~pend[0]};

  always_comb begin
    pend_clr    = '0;
    pend_clr[0] = ~int0 & pend[0];
    // End of service
    if (cp2_negedge & ack & int_req) begin
      pend_clr = pend_clr | grant;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | pend_set;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fetch latch and priority

  // MK bits follow the full source numbering
  assign enable = {ie & ~mk[ii_int2], ie & ~mk[ii_int1], ie & ~mk[ii_int0]};

  always_ff @(posedge CLK) begin
    if (rst) begin
      latched <= '0;
    end else if (cp2_negedge & fetch) begin
      latched <= pend & enable;
    end
  end

  always_comb begin
    grant = '0;
    if (latched[0]) begin
      grant[0] = 1'b1;
    end else if (latched[1]) begin
      grant[1] = 1'b1;
    end else if (latched[2]) begin
      grant[2] = 1'b1;
    end
  end

  assign int_req = |latched;

  always_comb begin
    case (grant)
      3'b001:  int_vector = vec_int0;
      3'b010:  int_vector = vec_int1;
      3'b100:  int_vector = vec_int2;
      default: int_vector = vec_none;
    endcase
  end

endmodule

//--- port_regs.sv
// Port, mode and interrupt mask registers with the IE flag.
// All writes commit on cp2_negedge cycles.
// A set mode bit makes the port bit an input; PC bits 6..2 are always
// outputs. Reads of PB and PC return the pin on input bits.

`timescale 1ns/1ps

module port_regs (
  input  logic       CLK,
  input  logic       rst,
  input  logic       cp2_negedge,
  spr_bus_if.regs    bus,
  input  logic       ei,
  input  logic       di,
  input  logic [7:0] pb_in,
  input  logic [7:0] pc_in,
  output logic [7:0] pa,
  output logic [7:0] pb,
  output logic [7:0] pc,
  output logic [7:0] pb_oe,
  output logic [7:0] pc_oe,
  output logic       ie,
  output logic [7:0] mk
);
  import upd7800_pkg::*;

  logic [7:0] mb;
  logic [7:0] mc;
  logic       wr;

  assign wr = cp2_negedge & bus.we;

  //////////////////////////////////////////////////////////////////////
  // Register writes

  always_ff @(posedge CLK) begin
    if (rst) begin
      pa <= '0;
      pb <= '0;
      pc <= '0;
      mk <= mk_reset;
      mb <= mode_reset;
      mc <= mode_reset;
    end else if (wr) begin
      case (bus.sel)
        spr_pa:  pa <= bus.wdata;
        spr_pb:  pb <= bus.wdata;
        spr_pc:  pc <= bus.wdata;
        spr_mk:  mk <= bus.wdata;
        spr_mb:  mb <= bus.wdata;
        spr_mc:  mc <= bus.wdata;
        default: ;
      endcase
    end
  end

  // DI has priority over EI
  always_ff @(posedge CLK) begin
    if (rst) begin
      ie <= 1'b0;
    end else if (cp2_negedge) begin
      if (di) begin
        ie <= 1'b0;
      end else if (ei) begin
        ie <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Direction and read-back

  assign pb_oe = ~mb;
  assign pc_oe = {~mc[7], 5'b11111, ~mc[1:0]};

  always_comb begin
    case (bus.sel)
      spr_pa:  bus.rdata = pa;
      spr_pb:  bus.rdata = (pb_in & ~pb_oe) | (pb & pb_oe);
      spr_pc:  bus.rdata = (pc_in & ~pc_oe) | (pc & pc_oe);
      spr_mk:  bus.rdata = mk;
      spr_mb:  bus.rdata = mb;
      spr_mc:  bus.rdata = mc;
      // Unused selects read as zero
      default: bus.rdata = 8'h00;
    endcase
  end

endmodule

//--- upd7800_periph.sv
// Peripheral side of a uPD7800-class MCU with ports, mode/mask registers,
// the IE flag and the INT0/INT1/INT2 interrupt controller.
// cp1_posedge paces INT1/INT2 sampling; cp2_negedge commits all
// register, IE and fetch/ack updates.

`timescale 1ns/1ps

module upd7800_periph (
  input  logic       CLK,
  input  logic       rst,
  input  logic       cp1_posedge,
  input  logic       cp2_negedge,
  input  logic [3:0] spr_sel,
  input  logic [7:0] spr_wdata,
  input  logic       spr_we,
  output logic [7:0] spr_rdata,
  input  logic       ei,
  input  logic       di,
  input  logic       int0,
  input  logic       int1,
  input  logic       int2,
  input  logic       fetch,
  input  logic       ack,
  output logic       int_req,
  output logic [7:0] int_vector,
  output logic [7:0] pa,
  input  logic [7:0] pb_in,
  output logic [7:0] pb,
  output logic [7:0] pb_oe,
  input  logic [7:0] pc_in,
  output logic [7:0] pc,
  output logic [7:0] pc_oe
);
  import upd7800_pkg::*;

  logic       ie;
  logic [7:0] mk;

  spr_bus_if u_bus ();

  // Host side of the SPR bus
  assign u_bus.sel   = e_spr'(spr_sel);
  assign u_bus.wdata = spr_wdata;
  assign u_bus.we    = spr_we;
  assign spr_rdata   = u_bus.rdata;

  port_regs u_regs (
    .CLK         (CLK),
    .rst         (rst),
    .cp2_negedge (cp2_negedge),
    .bus         (u_bus.regs),
    .ei          (ei),
    .di          (di),
    .pb_in       (pb_in),
    .pc_in       (pc_in),
    .pa          (pa),
    .pb          (pb),
    .pc          (pc),
    .pb_oe       (pb_oe),
    .pc_oe       (pc_oe),
    .ie          (ie),
    .mk          (mk)
  );

  int_controller u_intc (
    .CLK         (CLK),
    .rst         (rst),
    .cp1_posedge (cp1_posedge),
    .cp2_negedge (cp2_negedge),
    .int0        (int0),
    .int1        (int1),
    .int2        (int2),
    .fetch       (fetch),
    .ack         (ack),
    .ie          (ie),
    .mk          (mk),
    .int_req     (int_req),
    .int_vector  (int_vector)
  );

endmodule

//--- tb_upd7800_periph.sv
// Testbench for the uPD7800 peripheral block.
// A cycle model runs on every rising edge and all outputs are compared
// with it on each falling edge while reset is low.
// Inputs change on the rising edge. Random stimulus uses a fixed seed.

`timescale 1ns/1ps

module tb_upd7800_periph;
  import upd7800_pkg::*;

  localparam int reset_len   = 3;
  localparam int traffic_ops = 200;
  localparam int seg_count   = 24;
  localparam int max_hold    = 120;
  // About 400 directed cycles plus up to max_hold + 16 per random segment
  localparam int watchdog_cycles = 5 * reset_len + traffic_ops
                                   + seg_count * (max_hold + 16) + 400 + 1000;

  logic       CLK = 1'b0;
  logic       cp1_posedge = 1'b0;
  logic       cp2_negedge = 1'b1;
  logic       rst, spr_we, ei, di, fetch, ack, int0, int1, int2, int_req;
  logic [3:0] spr_sel;
  logic [7:0] spr_wdata, spr_rdata, int_vector, pb_in, pc_in;
  logic [7:0] pa, pb, pc, pb_oe, pc_oe;

  // Model state
  logic [7:0] m_pa, m_pb, m_pc, m_mk, m_mb, m_mc;
  logic [3:0] m_cnt, m_h1, m_h2;
  logic [2:0] m_pend, m_lat;
  logic       m_ie;

  integer seed = 29;
  int     checks = 0;
  int     errors = 0;
  int     test_start = 0;

  upd7800_periph u_dut (.*);

  always #20 CLK = ~CLK;

  // cp1 and cp2 strobes on alternate cycles
  always @(posedge CLK) begin
    cp1_posedge <= ~cp1_posedge;
    cp2_negedge <= cp1_posedge;
  end

  function automatic int unsigned rand_range(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH time=%0t signal=%s got=%02h expected=%02h", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model

  always @(posedge CLK) begin : ref_model
    logic [3:0] n1, n2;
    logic       smp;
    logic [2:0] grant, set, clr, en;
    smp   = cp1_posedge && (m_cnt == 4'd11);
    n1    = {m_h1[2:0], int1};
    // Clear MK bit 5 means falling INT2 edges
    n2    = {m_h2[2:0], m_mk[5] ? int2 : !int2};
    grant = m_lat[0] ? 3'b001 : (m_lat[1] ? 3'b010 : {m_lat[2], 2'b00});
    set   = {smp && n2 == 4'b0111, smp && n1 == 4'b0111, int0 && !m_pend[0]};
    clr   = {2'b00, !int0 && m_pend[0]};
    if (cp2_negedge && ack && |m_lat) begin
      clr = clr | grant;
    end
    en    = {3{m_ie}} & ~{m_mk[3], m_mk[2], m_mk[0]};
    if (rst) begin
      {m_pa, m_pb, m_pc, m_ie, m_cnt, m_h1, m_h2, m_pend, m_lat} = '0;
      {m_mk, m_mb, m_mc} = {3{8'hff}};
    end else begin
      if (cp1_posedge) begin
        m_cnt = smp ? 4'd0 : m_cnt + 4'd1;
      end
      if (smp) begin
        m_h1 = n1;
        m_h2 = n2;
      end
      if (cp2_negedge && fetch) begin
        m_lat = m_pend & en;
      end
      m_pend = (m_pend & ~clr) | set;
      if (cp2_negedge) begin
        m_ie = di ? 1'b0 : (ei ? 1'b1 : m_ie);
      end
      if (cp2_negedge && spr_we) begin
        case (spr_sel)
          spr_pa:  m_pa = spr_wdata;
          spr_pb:  m_pb = spr_wdata;
          spr_pc:  m_pc = spr_wdata;
          spr_mk:  m_mk = spr_wdata;
          spr_mb:  m_mb = spr_wdata;
          spr_mc:  m_mc = spr_wdata;
          default: ;
        endcase
      end
    end
  end

  task automatic check_outputs();
    logic [7:0] pc_in_bits;
    logic [7:0] rd;
    // PC bits 6..2 are always outputs
    pc_in_bits = m_mc & 8'h83;
    case (spr_sel)
      spr_pa:  rd = m_pa;
      spr_pb:  rd = (pb_in & m_mb) | (m_pb & ~m_mb);
      spr_pc:  rd = (pc_in & pc_in_bits) | (m_pc & ~pc_in_bits);
      spr_mk:  rd = m_mk;
      spr_mb:  rd = m_mb;
      spr_mc:  rd = m_mc;
      default: rd = 8'h00;
    endcase
    if (!rst) begin
      compare("spr_rdata", spr_rdata, rd);
      compare("pa", pa, m_pa);
      compare("pb", pb, m_pb);
      compare("pc", pc, m_pc);
      compare("pb_oe", pb_oe, ~m_mb);
      compare("pc_oe", pc_oe, ~pc_in_bits);
      compare("int_req", {7'd0, int_req}, {7'd0, |m_lat});
      compare("int_vector", int_vector,
              m_lat[0] ? 8'h04 : (m_lat[1] ? 8'h10 : (m_lat[2] ? 8'h20 : 8'h60)));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers are entered and left at a rising edge

  task automatic step(input int n);
    repeat (n) begin
      @(negedge CLK);
      check_outputs();
      @(posedge CLK);
    end
  endtask

  task automatic apply_reset();
    {rst, fetch, ack, ei, di, int0, int1, int2, spr_we} <= 9'h100;
    step(reset_len);
    rst <= 1'b0;
  endtask

  // Held two cycles so exactly one cp2 cycle sees it
  task automatic pulse_strobes(input logic f, input logic a, input logic e, input logic d);
    {fetch, ack, ei, di} <= {f, a, e, d};
    step(2);
    {fetch, ack, ei, di} <= 4'b0000;
    step(1);
  endtask

  task automatic write_reg(input logic [3:0] sel, input logic [7:0] data);
    spr_sel   <= sel;
    spr_wdata <= data;
    spr_we    <= 1'b1;
    step(2);
    spr_we <= 1'b0;
  endtask

  task automatic check_int(input logic req, input logic [7:0] vec);
    @(negedge CLK);
    check_outputs();
    compare("int_req", {7'd0, int_req}, {7'd0, req});
    compare("int_vector", int_vector, vec);
    @(posedge CLK);
  endtask

  task automatic read_expect(input logic [3:0] sel, input logic [7:0] value);
    spr_sel <= sel;
    @(negedge CLK);
    check_outputs();
    compare("spr_rdata", spr_rdata, value);
    @(posedge CLK);
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - test_start);
    test_start = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests

  initial begin
    rst = 1'b1;
    {spr_we, ei, di, fetch, ack, int0, int1, int2} = '0;
    spr_sel = 4'd0;
    {spr_wdata, pb_in, pc_in} = '0;
    @(posedge CLK);

    apply_reset();
    @(negedge CLK);
    compare("pa", pa, 8'h00);
    compare("pb", pb, 8'h00);
    compare("pc", pc, 8'h00);
    compare("pb_oe", pb_oe, 8'h00);
    compare("pc_oe", pc_oe, 8'h7c);
    @(posedge CLK);
    check_int(1'b0, 8'h60);
    read_expect(spr_mk, 8'hff);
    read_expect(spr_mb, 8'hff);
    read_expect(spr_mc, 8'hff);
    report_test(1, "reset values");

    repeat (traffic_ops) begin
      spr_sel   <= 4'(rand_range(6));
      spr_wdata <= 8'(rand_range(256));
      spr_we    <= 1'(rand_range(2));
      pb_in     <= 8'(rand_range(256));
      pc_in     <= 8'(rand_range(256));
      step(1);
    end
    spr_we <= 1'b0;
    report_test(2, "register traffic");

    apply_reset();
    write_reg(spr_mk, 8'hfe);
    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    int0 <= 1'b1;
    step(3);
    pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
    check_int(1'b1, 8'h04);
    int0 <= 1'b0;
    step(3);
    pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
    check_int(1'b0, 8'h60);
    report_test(3, "int0 level");

    // Hold times around the three-sample window of 72 cycles
    apply_reset();
    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    for (int s = 0; s < seg_count; s++) begin
      if (s % 6 == 0) begin
        write_reg(spr_mk, {2'b00, 1'((s / 6) % 2), 5'b00000});
      end
      int1 <= 1'(rand_range(2));
      int2 <= 1'(rand_range(2));
      step(8 + int'(rand_range(max_hold)));
      pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
      pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
    end
    report_test(4, "int1/int2 edge filter");

    apply_reset();
    write_reg(spr_mk, 8'h20);
    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    step(100);
    {int1, int2} <= 2'b11;
    step(100);
    int0 <= 1'b1;
    step(3);
    pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
    check_int(1'b1, 8'h04);
    write_reg(spr_mk, 8'hff);
    pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
    check_int(1'b0, 8'h60);
    write_reg(spr_mk, 8'h20);
    pulse_strobes(1'b0, 1'b0, 1'b0, 1'b1);
    pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
    check_int(1'b0, 8'h60);
    pulse_strobes(1'b0, 1'b0, 1'b1, 1'b0);
    pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
    check_int(1'b1, 8'h04);
    int0 <= 1'b0;
    step(3);
    // Ack then fetch walks down INT1, INT2, none
    for (int i = 0; i < 3; i++) begin
      pulse_strobes(1'b0, 1'b1, 1'b0, 1'b0);
      pulse_strobes(1'b1, 1'b0, 1'b0, 1'b0);
      check_int(i < 2, (i == 0) ? 8'h10 : ((i == 1) ? 8'h20 : 8'h60));
    end
    report_test(5, "priority, mask and ack");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Timeout: tests still running after %0d cycles", watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- filelist.f
upd7800_pkg.sv
spr_bus_if.sv
int_sampler.sv
int_controller.sv
port_regs.sv
upd7800_periph.sv
tb_upd7800_periph.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_upd7800_periph -f filelist.f -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if grep -q "ALL CHECKS PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
